/* dv/sifhTb.sv */
// self-checking testbench for the two-pass SiFH timing block
// frames expand from a stimulus table and a behavioral model predicts each result
`timescale 1ns/100ps

module sifhTb;

    localparam int passLen = sifhCfgPkg::acqNum * sifhCfgPkg::pixelNum *
                             sifhCfgPkg::samplesPerPixel;
    localparam int idleCycles = 6;
    localparam int rowNum = 6;
    // a frame takes well under a hundred cycles
    localparam int watchdogCycles = 2000 * rowNum;

    // per-pixel targets with pixel 3 in the top slot
    typedef struct packed {
        logic [sifhCfgPkg::pixelNum-1:0][sifhCfgPkg::timeBits-1:0] targets;
        logic [7:0] spread;
        logic [7:0] noiseCnt;
        // first offset of the outlier groups or zero for none
        logic [7:0] outlier;
    } stimRow_t;

    logic clk;
    logic combin_res;
    logic wrEn;
    sifhTypesPkg::tofSample_u data;
    sifhTypesPkg::pixelResults_t result;
    logic resultValid;
    logic pass;

    stimRow_t stimTable [rowNum];
    logic [sifhCfgPkg::timeBits-1:0] frameSamples [passLen];
    logic [31:0] seed;
    sifhTypesPkg::pixelResults_t expected;

    sifhTop sifhTop_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .data       (data),
        .result     (result),
        .resultValid(resultValid),
        .pass       (pass)
    );

    always #4 clk = ~clk;

    //************************************************************************
    // checks
    //************************************************************************
    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic compareResult(input sifhTypesPkg::pixelResults_t want,
                                 input sifhTypesPkg::pixelResults_t got);
        if (got !== want) begin
            stopOnError($sformatf("Error: result expected %h got %h", want, got));
        end
    endtask

    // single-bit outputs such as pass and resultValid
    task automatic expectFlag(input string name, input logic want, input logic got);
        if (got !== want) begin
            stopOnError($sformatf("Error: %s expected %h got %h", name, want, got));
        end
    endtask

    //************************************************************************
    // stimulus generation and reference model
    //************************************************************************
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // all samples on target before outliers and noise move some of them
    task automatic buildFrame(input int r);
        stimRow_t row;
        int idx;
        int span;
        int v;
        int slot;
        row = stimTable[r];
        span = 2 * row.spread + 1;
        for (int i = 0; i < passLen; i++) begin
            // position of the sample among the hits of its pixel
            slot = (i / (sifhCfgPkg::pixelNum * sifhCfgPkg::samplesPerPixel)) *
                   sifhCfgPkg::samplesPerPixel + i % sifhCfgPkg::samplesPerPixel;
            frameSamples[i] = row.targets[(i / sifhCfgPkg::samplesPerPixel) % sifhCfgPkg::pixelNum];
            // three on target, the rest in groups of 2, 2 and 1 spaced 32 codes apart
            // unfiltered they would share one fine bin and outvote the target
            if (row.outlier != 0 && slot >= 3) begin
                frameSamples[i] = frameSamples[i] + row.outlier + 8'(32 * ((slot - 3) / 2));
            end
        end
        for (int n = 0; n < row.noiseCnt; n++) begin
            seed = lcgNext(seed);
            idx = int'((seed >> 8) % passLen);
            seed = lcgNext(seed);
            v = int'(frameSamples[idx]) + int'((seed >> 8) % span) - int'(row.spread);
            // saturate into the timestamp range
            v = (v < 0) ? 0 : ((v > 255) ? 255 : v);
            frameSamples[idx] = v[7:0];
        end
    endtask

    // replays both passes in sample order with strictly greater winning
    function automatic sifhTypesPkg::pixelResults_t predictResult();
        int hist [sifhCfgPkg::pixelNum * sifhCfgPkg::binNum];
        int best [sifhCfgPkg::pixelNum];
        int peak [sifhCfgPkg::pixelNum];
        int base [sifhCfgPkg::pixelNum];
        int pix;
        int bin;
        sifhTypesPkg::pixelResults_t res;
        for (int p = 0; p < sifhCfgPkg::pixelNum; p++) begin
            base[p] = 0;
        end
        for (int ps = 0; ps < 2; ps++) begin
            for (int k = 0; k < sifhCfgPkg::pixelNum * sifhCfgPkg::binNum; k++) begin
                hist[k] = 0;
            end
            for (int p = 0; p < sifhCfgPkg::pixelNum; p++) begin
                best[p] = 0;
                peak[p] = 0;
            end
            for (int i = 0; i < passLen; i++) begin
                pix = (i / sifhCfgPkg::samplesPerPixel) % sifhCfgPkg::pixelNum;
                // coarse bin from the top five bits and fine bin relative to base
                bin = (ps == 0) ? (frameSamples[i] >> sifhCfgPkg::fineBits)
                                : int'(frameSamples[i]) - base[pix];
                if (bin >= 0 && bin < sifhCfgPkg::binNum) begin
                    hist[pix * sifhCfgPkg::binNum + bin]++;
                    if (hist[pix * sifhCfgPkg::binNum + bin] > best[pix]) begin
                        best[pix] = hist[pix * sifhCfgPkg::binNum + bin];
                        peak[pix] = bin;
                    end
                end
            end
            for (int p = 0; p < sifhCfgPkg::pixelNum && ps == 0; p++) begin
                base[p] = peak[p] * 8 - sifhCfgPkg::halfWindow;
                base[p] = (base[p] < 0) ? 0 : base[p];
                base[p] = (base[p] > sifhCfgPkg::windowMax) ? sifhCfgPkg::windowMax : base[p];
            end
        end
        for (int p = 0; p < sifhCfgPkg::pixelNum; p++) begin
            res[p] = sifhCfgPkg::timeBits'(peak[p] + base[p]);
        end
        return res;
    endfunction

    //************************************************************************
    // one pass of back-to-back samples followed by the idle gap
    //************************************************************************
    task automatic runPass(input int passIdx);
        int validAt;
        validAt = 0;
        for (int i = 0; i < passLen; i++) begin
            @(posedge clk);
            wrEn <= 1'b1;
            data.raw <= frameSamples[i];
            @(negedge clk);
            // flag flips only once the last sample is taken
            expectFlag("pass", passIdx[0], pass);
            expectFlag("resultValid", 1'b0, resultValid);
        end
        for (int k = 1; k <= idleCycles; k++) begin
            @(posedge clk);
            wrEn <= 1'b0;
            @(negedge clk);
            expectFlag("pass", passIdx == 0, pass);
            if (resultValid) begin
                if (passIdx == 0 || validAt != 0) begin
                    stopOnError("resultValid pulsed outside the end of the fine pass");
                end
                validAt = k;
                compareResult(expected, result);
            end
        end
        if (passIdx == 1 && validAt != sifhCfgPkg::pipeDepth + 1) begin
            stopOnError($sformatf("resultValid came %0d cycles after the last sample", validAt));
        end
    endtask

    initial begin
        clk = 1'b0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        data = '0;
        seed = 32'hdbc01fbe;
        // clean frame
        stimTable[0] = '{targets: {8'h80, 8'hc3, 8'h21, 8'h5a},
                         spread: 8'd0, noiseCnt: 8'd0, outlier: 8'd0};
        // clamping near both ends of the code range
        stimTable[1] = '{targets: {8'hff, 8'h0c, 8'hfa, 8'h02},
                         spread: 8'd0, noiseCnt: 8'd0, outlier: 8'd0};
        // wide noise lands outside the fine windows
        stimTable[2] = '{targets: {8'hf8, 8'h05, 8'hee, 8'h10},
                         spread: 8'd40, noiseCnt: 8'd10, outlier: 8'd0};
        // tight noise on bin edges makes ties likely
        stimTable[3] = '{targets: {8'hb8, 8'h3f, 8'h88, 8'h47},
                         spread: 8'd3, noiseCnt: 8'd14, outlier: 8'd0};
        stimTable[4] = '{targets: {8'h11, 8'h99, 8'h64, 8'hd7},
                         spread: 8'd0, noiseCnt: 8'd0, outlier: 8'd0};
        // outlier groups that only the window check keeps out
        stimTable[5] = '{targets: {8'he3, 8'h4d, 8'hfc, 8'h07},
                         spread: 8'd0, noiseCnt: 8'd0, outlier: 8'd40};
        repeat (8) @(posedge clk);
        combin_res <= 1'b1;
        for (int r = 0; r < rowNum; r++) begin
            buildFrame(r);
            expected = predictResult();
            runPass(0);
            runPass(1);
        end
        $display("=== PASS ===");
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        stopOnError("timeout, the run did not finish within the cycle budget");
    end

endmodule

/* list.f */
rtl/sifhCfgPkg.sv
rtl/sifhTypesPkg.sv
rtl/frameSequencer.sv
rtl/sampleFilter.sv
rtl/histBuilder.sv
rtl/peakTracker.sv
rtl/windowCalc.sv
rtl/sifhTop.sv
dv/sifhTb.sv

/* rtl/frameSequencer.sv */
// tracks the position of each strobe inside a frame
// gives the pixel index, the pass flag and the pass start and end pulses
`timescale 1ns/100ps

module frameSequencer (
    input  logic                             clk,
    input  logic                             combin_res,
    input  logic                             wrEn,
    output logic [sifhCfgPkg::pixelBits-1:0] pixel,
    output logic                             pass,
    output logic                             passStart,
    output logic                             passEnd
);

    logic [sifhCfgPkg::sampleBits-1:0] sampleCnt;
    logic [sifhCfgPkg::acqBits-1:0] acqCnt;
    logic lastOfPixel;
    logic lastOfAcq;
    logic lastOfPass;
    logic [sifhCfgPkg::pipeDepth-1:0] endPipe;

    // wrap points of the nested counters
    assign lastOfPixel = (sampleCnt == sifhCfgPkg::sampleBits'(sifhCfgPkg::samplesPerPixel - 1));
    assign lastOfAcq = lastOfPixel && (pixel == sifhCfgPkg::pixelBits'(sifhCfgPkg::pixelNum - 1));
    assign lastOfPass = lastOfAcq && (acqCnt == sifhCfgPkg::acqBits'(sifhCfgPkg::acqNum - 1));

    // first strobe of a pass, all counters at zero
    assign passStart = wrEn && (sampleCnt == '0) && (pixel == '0) && (acqCnt == '0);

    //************************************************************************
    // sample / pixel / acquisition counters
    //************************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel <= '0;
            acqCnt <= '0;
            pass <= 1'b0;
        end else if (wrEn) begin
            sampleCnt <= lastOfPixel ? '0 : sampleCnt + 1'b1;
            if (lastOfPixel) begin
                pixel <= lastOfAcq ? '0 : pixel + 1'b1;
            end
            if (lastOfAcq) begin
                acqCnt <= lastOfPass ? '0 : acqCnt + 1'b1;
            end
            // flips right after the last sample, filter already has it
            if (lastOfPass) begin
                pass <= ~pass;
            end
        end
    end

    // end strobe delayed until filter, histogram and tracker drained
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            endPipe <= '0;
        end else begin
            endPipe <= {endPipe[sifhCfgPkg::pipeDepth-2:0], wrEn && lastOfPass};
        end
    end

    assign passEnd = endPipe[sifhCfgPkg::pipeDepth-1];

endmodule

/* rtl/histBuilder.sv */
// per-pixel histogram in registers, one counter per bin
// per-bin valid bits stand in for a clearing sweep at pass start
`timescale 1ns/100ps

module histBuilder (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    clear,
    input  sifhTypesPkg::binHit_t   hit,
    output sifhTypesPkg::binCount_t update
);

    localparam int depth = sifhCfgPkg::pixelNum * sifhCfgPkg::binNum;
    localparam int addrBits = sifhCfgPkg::pixelBits + sifhCfgPkg::binBits;

    logic [sifhCfgPkg::countBits-1:0] binMem [depth];
    logic [depth-1:0] binValid;
    logic [addrBits-1:0] addr;
    logic [sifhCfgPkg::countBits-1:0] newCount;

    // pixel picks the block, bin the entry
    assign addr = {hit.pixel, hit.bin};

    // stale entry counts as empty
    assign newCount = binValid[addr] ? binMem[addr] + 1'b1 : sifhCfgPkg::countBits'(1);

    //************************************************************************
    // counter storage
    //************************************************************************
    always_ff @(posedge clk) begin
        if (hit.valid) begin
            binMem[addr] <= newCount;
        end
    end

    // valid bits, dropped all at once on clear
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (clear) begin
            binValid <= '0;
        end else if (hit.valid) begin
            binValid[addr] <= 1'b1;
        end
    end

    // new count out to the tracker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            update <= '0;
        end else begin
            update.valid <= hit.valid;
            update.pixel <= hit.pixel;
            update.bin <= hit.bin;
            update.count <= newCount;
        end
    end

endmodule

/* rtl/peakTracker.sv */
// running maximum of the histogram counts, kept per pixel
// strictly greater replaces, so the first bin to reach the top stays
`timescale 1ns/100ps

module peakTracker (
    input  logic                    clk,
    input  logic                    combin_res,
    input  logic                    clear,
    input  sifhTypesPkg::binCount_t update,
    output sifhTypesPkg::peakBins_t peakBins
);

    logic [sifhCfgPkg::countBits-1:0] maxCount [sifhCfgPkg::pixelNum];
    logic isHigher;

    // compare against the best count of the updated pixel
    assign isHigher = update.valid && (update.count > maxCount[update.pixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakBins <= '0;
            for (int p = 0; p < sifhCfgPkg::pixelNum; p++) begin
                maxCount[p] <= '0;
            end
        end else if (clear) begin
            // new pass, forget the old peaks
            peakBins <= '0;
            for (int p = 0; p < sifhCfgPkg::pixelNum; p++) begin
                maxCount[p] <= '0;
            end
        end else if (isHigher) begin
            maxCount[update.pixel] <= update.count;
            peakBins[update.pixel] <= update.bin;
        end
    end

endmodule

/* rtl/sampleFilter.sv */
// turns each timestamp into a histogram bin for the running pass
// coarse bin in pass 0, window-relative code in pass 1, registered out
`timescale 1ns/100ps

module sampleFilter (
    input  logic                             clk,
    input  logic                             combin_res,
    input  logic                             wrEn,
    input  sifhTypesPkg::tofSample_u         data,
    input  logic [sifhCfgPkg::pixelBits-1:0] pixel,
    input  logic                             pass,
    input  sifhTypesPkg::pixelWindows_t      windows,
    output sifhTypesPkg::binHit_t            hit
);

    logic [sifhCfgPkg::timeBits-1:0] base;
    logic [sifhCfgPkg::timeBits-1:0] offset;
    logic inWindow;
    sifhTypesPkg::binHit_t nextHit;

    // window of the pixel now being fed
    assign base = windows[pixel];
    assign offset = data.raw - base;
    // above base and less than binNum codes past it
    assign inWindow = (data.raw >= base) &&
                      (offset[sifhCfgPkg::timeBits-1:sifhCfgPkg::binBits] == '0);

    always_comb begin
        nextHit.pixel = pixel;
        if (pass) begin
            // fine pass, full resolution relative to base
            nextHit.valid = wrEn && inWindow;
            nextHit.bin = offset[sifhCfgPkg::binBits-1:0];
        end else begin
            // coarse pass, upper bits only
            nextHit.valid = wrEn;
            nextHit.bin = data.split.coarseBin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit <= '0;
        end else begin
            hit <= nextHit;
        end
    end

endmodule

/* rtl/sifhCfgPkg.sv */
// sizing constants for the SiFH timing block
// shared by every RTL stage and by the testbench model
package sifhCfgPkg;

    // timestamp split, coarse bin on top and fine code below
    localparam int timeBits = 8;
    localparam int binBits = 5;
    localparam int fineBits = timeBits - binBits;
    localparam int binNum = 1 << binBits;

    // frame layout
    localparam int pixelNum = 4;
    localparam int pixelBits = $clog2(pixelNum);
    localparam int samplesPerPixel = 2;
    localparam int sampleBits = $clog2(samplesPerPixel);
    localparam int acqNum = 4;
    localparam int acqBits = $clog2(acqNum);

    // 8 hits per pixel per pass at most
    localparam int countBits = 6;

    // filter, histogram and tracker stages
    localparam int pipeDepth = 3;

    // fine window placement
    localparam int halfWindow = 16;
    localparam int windowMax = 224;

endpackage

/* rtl/sifhTop.sv */
// top of the two-pass SiFH timing block
// feed timestamps with wrEn in frame order, read result on resultValid
`timescale 1ns/100ps

module sifhTop (
    input  logic                        clk,
    input  logic                        combin_res,
    input  logic                        wrEn,
    input  sifhTypesPkg::tofSample_u    data,
    output sifhTypesPkg::pixelResults_t result,
    output logic                        resultValid,
    output logic                        pass
);

    //************************************************************************
    // inter-stage wires
    //************************************************************************
    logic [sifhCfgPkg::pixelBits-1:0] pixel;
    logic passStart;
    logic passEnd;
    sifhTypesPkg::binHit_t hit;
    sifhTypesPkg::binCount_t update;
    sifhTypesPkg::peakBins_t peakBins;
    sifhTypesPkg::pixelWindows_t windows;

    // frame position and pass control
    frameSequencer frameSequencer_i (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .pixel     (pixel),
        .pass      (pass),
        .passStart (passStart),
        .passEnd   (passEnd)
    );

    // sample to bin, window check in pass 1
    sampleFilter sampleFilter_i (
        .clk       (clk),
        .combin_res(combin_res),
        .wrEn      (wrEn),
        .data      (data),
        .pixel     (pixel),
        .pass      (pass),
        .windows   (windows),
        .hit       (hit)
    );

    histBuilder histBuilder_i (
        .clk       (clk),
        .combin_res(combin_res),
        .clear     (passStart),
        .hit       (hit),
        .update    (update)
    );

    peakTracker peakTracker_i (
        .clk       (clk),
        .combin_res(combin_res),
        .clear     (passStart),
        .update    (update),
        .peakBins  (peakBins)
    );

    // windows loop back to the filter
    windowCalc windowCalc_i (
        .clk        (clk),
        .combin_res (combin_res),
        .pass       (pass),
        .passEnd    (passEnd),
        .peakBins   (peakBins),
        .windows    (windows),
        .result     (result),
        .resultValid(resultValid)
    );

endmodule

/* rtl/sifhTypesPkg.sv */
// data words passed between the SiFH stages
// sample union, histogram traffic and per-pixel result vectors
package sifhTypesPkg;

    // timestamp seen as coarse bin plus fine code
    typedef struct packed {
        logic [sifhCfgPkg::binBits-1:0] coarseBin;
        logic [sifhCfgPkg::fineBits-1:0] fineCode;
    } tofSplit_t;

    // one raw timestamp, read either whole or split
    typedef union packed {
        logic [sifhCfgPkg::timeBits-1:0] raw;
        tofSplit_t split;
    } tofSample_u;

    // filtered sample headed for the histogram
    typedef struct packed {
        logic valid;
        logic [sifhCfgPkg::pixelBits-1:0] pixel;
        logic [sifhCfgPkg::binBits-1:0] bin;
    } binHit_t;

    // fresh bin count headed for the peak tracker
    typedef struct packed {
        logic valid;
        logic [sifhCfgPkg::pixelBits-1:0] pixel;
        logic [sifhCfgPkg::binBits-1:0] bin;
        logic [sifhCfgPkg::countBits-1:0] count;
    } binCount_t;

    // per-pixel vectors, pixel 0 in the low slot
    typedef logic [sifhCfgPkg::pixelNum-1:0][sifhCfgPkg::binBits-1:0] peakBins_t;
    typedef logic [sifhCfgPkg::pixelNum-1:0][sifhCfgPkg::timeBits-1:0] pixelWindows_t;
    typedef logic [sifhCfgPkg::pixelNum-1:0][sifhCfgPkg::timeBits-1:0] pixelResults_t;

endpackage

/* rtl/windowCalc.sv */
// derives the fine windows from the coarse peaks after pass 0
// and the final timestamps from the fine peaks after pass 1
`timescale 1ns/100ps

module windowCalc (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          pass,
    input  logic                          passEnd,
    input  sifhTypesPkg::peakBins_t       peakBins,
    output sifhTypesPkg::pixelWindows_t   windows,
    output sifhTypesPkg::pixelResults_t   result,
    output logic                          resultValid
);

    logic [sifhCfgPkg::timeBits-1:0] center [sifhCfgPkg::pixelNum];
    sifhTypesPkg::pixelWindows_t nextWindows;
    sifhTypesPkg::pixelResults_t nextResult;
    logic coarseDone;
    logic fineDone;

    // pass flag has already flipped by the time passEnd arrives
    assign coarseDone = passEnd && pass;
    assign fineDone = passEnd && !pass;

    //************************************************************************
    // window base: coarse peak scaled up, centred, clamped
    //************************************************************************
    always_comb begin
        for (int p = 0; p < sifhCfgPkg::pixelNum; p++) begin
            center[p] = {peakBins[p], {sifhCfgPkg::fineBits{1'b0}}};
            if (center[p] < sifhCfgPkg::timeBits'(sifhCfgPkg::halfWindow)) begin
                nextWindows[p] = '0;
            end else if (center[p] - sifhCfgPkg::timeBits'(sifhCfgPkg::halfWindow) >
                         sifhCfgPkg::timeBits'(sifhCfgPkg::windowMax)) begin
                // top end, keep base plus 31 inside the code range
                nextWindows[p] = sifhCfgPkg::timeBits'(sifhCfgPkg::windowMax);
            end else begin
                nextWindows[p] = center[p] - sifhCfgPkg::timeBits'(sifhCfgPkg::halfWindow);
            end
            // fine peak back to absolute time
            nextResult[p] = sifhCfgPkg::timeBits'(peakBins[p]) + windows[p];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windows <= '0;
            result <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= fineDone;
            if (coarseDone) begin
                windows <= nextWindows;
            end
            if (fineDone) begin
                result <= nextResult;
            end
        end
    end

endmodule
